// ==== common/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data path width
`define RV_XLEN 32

// Instruction memory word address for 256 words
`define RV_IMEM_AW 8

// Data memory word address for 64 words
`define RV_DMEM_AW 6

// Register index width and count
`define RV_REG_AW 5
`define RV_REG_NUM 32

`endif

// ==== common/rv_pkg.sv ====
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]    word_t;
    typedef logic [`RV_REG_AW-1:0]  reg_addr_t;
    typedef logic [`RV_IMEM_AW-1:0] imem_addr_t;
    typedef logic [`RV_DMEM_AW-1:0] dmem_addr_t;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_halt
    } cpu_state_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        cls_reg_alu,
        cls_imm_alu,
        cls_load,
        cls_store,
        cls_illegal
    } op_class_e;

    typedef struct packed {
        op_class_e op_class;
        alu_op_e   alu_op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;   // Zero for stores and illegal words
        word_t     imm;
    } decoded_inst_t;

    typedef struct packed {
        logic       valid;
        logic       target;  // 0 imem, 1 dmem
        imem_addr_t addr;    // Truncated for dmem
        word_t      data;
    } mem_load_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        reg_addr_t  rd;
        word_t      wdata;
        logic       is_store;
        dmem_addr_t store_addr;
        word_t      store_data;
    } retire_t;

endpackage

// ==== core/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control
    import rv_pkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  logic      start,
    input  op_class_e op_class,
    input  logic      last_inst,
    output logic      pc_clear,
    output logic      pc_step,
    output logic      imem_re,
    output logic      ir_load,
    output logic      opnd_load,
    output logic      res_load,
    output logic      dmem_re,
    output logic      dmem_we,
    output logic      rf_we,
    output logic      retire_valid,
    output logic      busy,
    output logic      done
);

    cpu_state_e state;
    cpu_state_e state_nxt;
    logic       is_mem;
    logic       waiting;

    assign is_mem  = (op_class == cls_load) || (op_class == cls_store);
    assign waiting = (state == st_idle) || (state == st_halt);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle,
            st_halt:      if (start) state_nxt = st_fetch;  // Fetch right after start
            st_fetch:     state_nxt = st_decode;
            st_decode:    state_nxt = st_execute;
            st_execute:   state_nxt = is_mem ? st_memory : st_writeback;
            st_memory:    state_nxt = st_writeback;
            st_writeback: state_nxt = last_inst ? st_halt : st_fetch;
            default:      state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign pc_clear     = waiting && start;
    assign pc_step      = (state == st_writeback) && !last_inst;
    assign imem_re      = (state == st_fetch);
    assign ir_load      = (state == st_decode);
    assign opnd_load    = (state == st_execute);  // Store data
    assign res_load     = (state == st_execute);
    assign dmem_re      = (state == st_memory) && (op_class == cls_load);
    assign dmem_we      = (state == st_memory) && (op_class == cls_store);
    assign rf_we        = (state == st_writeback) &&
                          (op_class inside {cls_reg_alu, cls_imm_alu, cls_load});
    assign retire_valid = (state == st_writeback);
    assign busy         = !waiting;
    assign done         = (state == st_halt);

    // A store always uses an address captured in the cycle before
    a_store_after_execute: assert property (@(posedge CLK) disable iff (RST)
        dmem_we |-> state == st_memory && $past(state) == st_execute);

    // Retire only closes an instruction that went through execute
    a_retire_in_writeback: assert property (@(posedge CLK) disable iff (RST)
        retire_valid |-> state == st_writeback &&
                         $past(state) inside {st_execute, st_memory});

endmodule

// ==== core/pc_counter.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module pc_counter
    import rv_pkg::*;
(
    input  logic       CLK,
    input  logic       RST,
    input  logic       clear,
    input  logic       step,
    input  imem_addr_t prog_len,
    output word_t      pc,
    output logic       last_inst
);

    imem_addr_t idx;
    imem_addr_t last_idx;  // Held for the whole run

    always_ff @(posedge CLK) begin
        if (RST) begin
            idx      <= '0;
            last_idx <= '0;
        end else if (clear) begin
            idx      <= '0;
            last_idx <= prog_len - 1'b1;
        end else if (step) begin
            idx <= idx + 1'b1;
        end
    end

    // Word index shown as byte address
    assign pc        = {{(`RV_XLEN - `RV_IMEM_AW - 2){1'b0}}, idx, 2'b00};
    assign last_inst = (idx == last_idx);

    a_pc_word_step: assert property (@(posedge CLK) disable iff (RST)
        step && !clear && !last_inst |=> pc[1:0] == 2'b00 && pc == $past(pc) + 32'd4);

endmodule

// ==== core/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder
    import rv_pkg::*;
(
    input  word_t         inst,
    output decoded_inst_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;
    word_t      imm_i;
    word_t      imm_s;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    assign imm_i = word_t'($signed(inst[31:20]));
    assign imm_s = word_t'($signed({inst[31:25], inst[11:7]}));

    always_comb begin
        dec.op_class = cls_illegal;
        dec.alu_op   = alu_add;  // lw and sw use add
        dec.rs1      = inst[19:15];
        dec.rs2      = inst[24:20];
        dec.rd       = inst[11:7];
        dec.imm      = imm_i;
        case (opcode)
            7'b0110011: begin  // R-type
                case (funct3)
                    3'b000: dec.alu_op = f7_alt ? alu_sub : alu_add;
                    3'b001: dec.alu_op = alu_sll;
                    3'b010: dec.alu_op = alu_slt;
                    3'b011: dec.alu_op = alu_sltu;
                    3'b100: dec.alu_op = alu_xor;
                    3'b101: dec.alu_op = f7_alt ? alu_sra : alu_srl;
                    3'b110: dec.alu_op = alu_or;
                    default: dec.alu_op = alu_and;
                endcase
                if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    dec.op_class = cls_reg_alu;
                end
            end
            7'b0010011: begin  // I-type ALU
                dec.op_class = cls_imm_alu;
                case (funct3)
                    3'b000: dec.alu_op = alu_add;
                    3'b010: dec.alu_op = alu_slt;
                    3'b011: dec.alu_op = alu_sltu;
                    3'b100: dec.alu_op = alu_xor;
                    3'b110: dec.alu_op = alu_or;
                    3'b111: dec.alu_op = alu_and;
                    3'b001: begin
                        dec.alu_op = alu_sll;
                        dec.imm    = word_t'(inst[24:20]);  // Shift amount only
                        if (!f7_zero) dec.op_class = cls_illegal;
                    end
                    default: begin
                        dec.alu_op = f7_alt ? alu_sra : alu_srl;
                        dec.imm    = word_t'(inst[24:20]);
                        if (!f7_zero && !f7_alt) dec.op_class = cls_illegal;
                    end
                endcase
            end
            7'b0000011: if (funct3 == 3'b010) dec.op_class = cls_load;  // lw
            7'b0100011: begin  // sw
                dec.imm = imm_s;
                if (funct3 == 3'b010) dec.op_class = cls_store;
            end
            default: dec.op_class = cls_illegal;
        endcase
        // No register write for these
        if (dec.op_class == cls_store || dec.op_class == cls_illegal) dec.rd = '0;
    end

endmodule

// ==== core/alu.sv ====
`timescale 1ns/1ps

module alu
    import rv_pkg::*;
(
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:  y = a + b;
            alu_sub:  y = a - b;
            alu_sll:  y = a << shamt;
            alu_slt:  y = word_t'($signed(a) < $signed(b));
            alu_sltu: y = word_t'(a < b);  // Unsigned compare
            alu_xor:  y = a ^ b;
            alu_srl:  y = a >> shamt;
            alu_sra:  y = word_t'($signed(a) >>> shamt);  // Keeps the sign bit
            alu_or:   y = a | b;
            alu_and:  y = a & b;
            default:  y = a + b;
        endcase
    end

endmodule

// ==== core/register_file.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module register_file
    import rv_pkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  reg_addr_t wa,
    input  word_t     wd,
    input  logic      we,
    output word_t     rd1,
    output word_t     rd2
);

    word_t regs [`RV_REG_NUM];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < `RV_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin  // x0 stays zero
            regs[wa] <= wd;
        end
    end

    // Combinational read
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    a_x0_zero: assert property (@(posedge CLK) disable iff (RST)
        ra1 == '0 |-> rd1 == '0);

endmodule

// ==== source/word_mem.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module word_mem
    import rv_pkg::*;
#(
    parameter int AW = `RV_IMEM_AW
) (
    input  logic          CLK,
    input  logic          re,
    input  logic [AW-1:0] raddr,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  word_t         wdata,
    output word_t         rdata
);

    word_t mem [2**AW];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr];  // Data one cycle after re
        end
    end

endmodule

// ==== source/rv_multicycle_top.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_multicycle_top
    import rv_pkg::*;
(
    input  logic       CLK,
    input  logic       RST,
    input  mem_load_t  load,
    input  logic       start,
    input  imem_addr_t prog_len,
    output logic       busy,
    output logic       done,
    output retire_t    retire
);

    logic          pc_clear;
    logic          pc_step;
    logic          last_inst;
    logic          imem_re;
    logic          ir_load;
    logic          opnd_load;
    logic          res_load;
    logic          dmem_re;
    logic          dmem_we;
    logic          rf_we;
    logic          retire_valid;
    logic          host_we;
    word_t         pc;
    word_t         imem_rdata;
    word_t         dmem_rdata;
    word_t         rd1;
    word_t         rd2;
    word_t         alu_b;
    word_t         alu_y;
    word_t         wb_data;
    decoded_inst_t dec;
    decoded_inst_t dec_q;   // Instruction register
    word_t         opnd_q;  // Store data
    word_t         alu_q;
    dmem_addr_t    dmem_addr;

    cpu_control u_ctrl (
        .CLK          (CLK),
        .RST          (RST),
        .start        (start),
        .op_class     (dec_q.op_class),
        .last_inst    (last_inst),
        .pc_clear     (pc_clear),
        .pc_step      (pc_step),
        .imem_re      (imem_re),
        .ir_load      (ir_load),
        .opnd_load    (opnd_load),
        .res_load     (res_load),
        .dmem_re      (dmem_re),
        .dmem_we      (dmem_we),
        .rf_we        (rf_we),
        .retire_valid (retire_valid),
        .busy         (busy),
        .done         (done)
    );

    pc_counter u_pc (
        .CLK       (CLK),
        .RST       (RST),
        .clear     (pc_clear),
        .step      (pc_step),
        .prog_len  (prog_len),
        .pc        (pc),
        .last_inst (last_inst)
    );

    // Host writes only while the core is stopped
    assign host_we = load.valid && !busy;

    word_mem #(.AW(`RV_IMEM_AW)) imem (
        .CLK   (CLK),
        .re    (imem_re),
        .raddr (pc[`RV_IMEM_AW+1:2]),
        .we    (host_we && !load.target),
        .waddr (load.addr),
        .wdata (load.data),
        .rdata (imem_rdata)
    );

    inst_decoder u_dec (
        .inst (imem_rdata),
        .dec  (dec)
    );

    register_file u_rf (
        .CLK (CLK),
        .RST (RST),
        .ra1 (dec_q.rs1),
        .ra2 (dec_q.rs2),
        .wa  (dec_q.rd),
        .wd  (wb_data),
        .we  (rf_we),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    assign alu_b = (dec_q.op_class == cls_reg_alu) ? rd2 : dec_q.imm;

    alu u_alu (
        .op (dec_q.alu_op),
        .a  (rd1),
        .b  (alu_b),
        .y  (alu_y)
    );

    always_ff @(posedge CLK) begin
        if (ir_load) dec_q <= dec;
        if (opnd_load) opnd_q <= rd2;
        if (res_load) alu_q <= alu_y;
    end

    assign dmem_addr = alu_q[`RV_DMEM_AW+1:2];  // Low two bits ignored

    word_mem #(.AW(`RV_DMEM_AW)) dmem (
        .CLK   (CLK),
        .re    (dmem_re),
        .raddr (dmem_addr),
        .we    (dmem_we || (host_we && load.target)),
        .waddr (busy ? dmem_addr : load.addr[`RV_DMEM_AW-1:0]),
        .wdata (busy ? opnd_q : load.data),
        .rdata (dmem_rdata)
    );

    assign wb_data = (dec_q.op_class == cls_load) ? dmem_rdata : alu_q;

    always_comb begin
        retire.valid      = retire_valid;
        retire.pc         = pc;
        retire.rd         = dec_q.rd;
        // Value that rd holds after the write
        retire.wdata      = (dec_q.rd == '0) ? '0 : wb_data;
        retire.is_store   = (dec_q.op_class == cls_store);
        retire.store_addr = dmem_addr;
        retire.store_data = opnd_q;
    end

endmodule

// ==== test/rv_multicycle_tb.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_multicycle_tb
    import rv_pkg::*;
();

    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LW  = 7'b0000011;
    localparam logic [6:0] OPC_SW  = 7'b0100011;

    localparam int KIND_REG    = 0;
    localparam int KIND_IMM    = 1;
    localparam int KIND_MIX    = 2;
    localparam int PROG_LEN    = 60;
    localparam int RESTART_LEN = 40;
    localparam int DMEM_WORDS  = 2 ** `RV_DMEM_AW;
    localparam int N_RUNS      = 4;
    localparam int INST_TOTAL  = 3 * PROG_LEN + RESTART_LEN;
    localparam int LOAD_CYCLES = 16 + INST_TOTAL + N_RUNS * (DMEM_WORDS + 1);
    localparam int TIMEOUT     = (5 * INST_TOTAL + LOAD_CYCLES) * 2 + 200;

    logic       CLK = 1'b0;
    logic       RST;
    mem_load_t  load;
    logic       start;
    imem_addr_t prog_len;
    logic       busy;
    logic       done;
    retire_t    retire;

    word_t prog [2 ** `RV_IMEM_AW];
    word_t xr [32];          // Model registers
    word_t dm [DMEM_WORDS];  // Model data memory
    word_t rng = 32'd74963;
    int    cycle = 0;
    int    test_num = 0;
    int    test_errors = 0;
    int    pass_count = 0;
    int    fail_count = 0;

    rv_multicycle_top uut (
        .CLK      (CLK),
        .RST      (RST),
        .load     (load),
        .start    (start),
        .prog_len (prog_len),
        .busy     (busy),
        .done     (done),
        .retire   (retire)
    );

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout: the core did not finish within %0d cycles", TIMEOUT);
            $display("sim failed");
            $finish;
        end
    end

    function automatic word_t xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // RV32I result for funct3 with alt selecting sub or sra
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]))
                             : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic word_t random_reg_op();
        word_t      r;
        logic [2:0] f3;
        logic       alt;
        r   = xorshift();
        f3  = r[2:0];
        alt = r[3] && (f3 == 3'b000 || f3 == 3'b101);
        return {1'b0, alt, 5'b0, r[8:4], r[13:9], f3, r[18:14], OPC_REG};
    endfunction

    function automatic word_t random_imm_op();
        word_t       r;
        logic [2:0]  f3;
        logic [11:0] imm;
        r   = xorshift();
        f3  = r[2:0];
        imm = r[14:3];
        if (f3 == 3'b001) imm = {7'b0, r[7:3]};
        if (f3 == 3'b101) imm = {1'b0, r[8], 5'b0, r[7:3]};  // srli or srai
        return {imm, r[19:15], f3, r[24:20], OPC_IMM};
    endfunction

    function automatic word_t random_mem_op(input logic store);
        word_t r;
        r = xorshift();
        if (store) return {r[11:5], r[21:17], r[16:12], 3'b010, r[4:0], OPC_SW};
        return {r[11:0], r[16:12], 3'b010, r[21:17], OPC_LW};
    endfunction

    task automatic build_program(input int kind, input int n);
        word_t r;
        for (int i = 0; i < n; i++) begin
            r = xorshift();
            if (kind == KIND_REG || (kind == KIND_MIX && r[1:0] == 2'd2)) begin
                prog[imem_addr_t'(i)] = random_reg_op();
            end else if (kind == KIND_IMM || r[1:0] == 2'd3) begin
                prog[imem_addr_t'(i)] = random_imm_op();
            end else begin
                prog[imem_addr_t'(i)] = random_mem_op(r[0]);
            end
        end
    endtask

    // Executes one instruction on the model state
    task automatic model_step(input word_t inst, output reg_addr_t rd, output word_t wdata,
                              output logic st, output dmem_addr_t saddr, output word_t sdata);
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_s;
        word_t addr;
        word_t res;
        a     = xr[inst[19:15]];
        b     = xr[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        rd    = inst[11:7];
        st    = 1'b0;
        saddr = '0;
        sdata = '0;
        res   = '0;
        case (inst[6:0])
            OPC_REG: res = alu_ref(inst[14:12], inst[30], a, b);
            OPC_IMM: res = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'b101, a,
                                   (inst[13:12] == 2'b01) ? {27'b0, inst[24:20]} : imm_i);
            OPC_LW: begin
                addr = a + imm_i;
                res  = dm[addr[7:2]];
            end
            default: begin
                addr  = a + imm_s;
                st    = 1'b1;
                saddr = addr[7:2];
                sdata = b;
                dm[addr[7:2]] = b;
                rd    = '0;
            end
        endcase
        if (rd != '0) xr[rd] = res;
        wdata = xr[rd];
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("error %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic idle_check();
        check_value("busy", 32'd0, 32'(busy));
        check_value("done", 32'd0, 32'(done));
        check_value("retire.valid", 32'd0, 32'(retire.valid));
    endtask

    task automatic load_word(input logic target, input imem_addr_t addr, input word_t data,
                             input logic check_idle);
        @(negedge CLK);
        if (check_idle) idle_check();
        load.valid  = 1'b1;
        load.target = target;
        load.addr   = addr;
        load.data   = data;
    endtask

    task automatic load_program(input int n, input logic check_idle);
        word_t w;
        for (int i = 0; i < n; i++) begin
            load_word(1'b0, imem_addr_t'(i), prog[imem_addr_t'(i)], check_idle);
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            w = xorshift();
            dm[dmem_addr_t'(i)] = w;
            load_word(1'b1, {w[1:0], dmem_addr_t'(i)}, w, check_idle);  // Top bits dropped
        end
        @(negedge CLK);
        if (check_idle) idle_check();
        load = '0;
    endtask

    task automatic run_program(input int n);
        int         retired;
        int         last_cycle;
        reg_addr_t  erd;
        word_t      ewd;
        logic       est;
        dmem_addr_t esa;
        word_t      esd;
        word_t      inst;
        logic       is_mem;
        @(negedge CLK);
        start      = 1'b1;
        prog_len   = imem_addr_t'(n);
        last_cycle = cycle;
        retired    = 0;
        do begin
            @(negedge CLK);
            start = 1'b0;
            if (!done) check_value("busy", 32'd1, 32'(busy));
            if (retire.valid && retired < n) begin
                inst   = prog[imem_addr_t'(retired)];
                is_mem = (inst[6:0] == OPC_LW) || (inst[6:0] == OPC_SW);
                model_step(inst, erd, ewd, est, esa, esd);
                check_value("pc", 32'(retired * 4), retire.pc);
                check_value("rd", 32'(erd), 32'(retire.rd));
                check_value("wdata", ewd, retire.wdata);
                check_value("is_store", 32'(est), 32'(retire.is_store));
                if (est) begin
                    check_value("store_addr", 32'(esa), 32'(retire.store_addr));
                    check_value("store_data", esd, retire.store_data);
                end
                check_value("retire gap", is_mem ? 32'd5 : 32'd4, 32'(cycle - last_cycle));
                last_cycle = cycle;
                retired++;
            end else if (retire.valid) begin
                $display("a retire arrived after the last instruction of the program");
                test_errors++;
            end
        end while (!done);
        check_value("retire count", 32'(n), 32'(retired));
        check_value("done delay", 32'd1, 32'(cycle - last_cycle));
        check_value("busy", 32'd0, 32'(busy));
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0d %s: passed", test_num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: failed with %0d errors", test_num, name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        RST      = 1'b1;
        start    = 1'b0;
        prog_len = '0;
        load     = '0;
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        repeat (16) @(negedge CLK);
        RST = 1'b0;
        idle_check();
        build_program(KIND_IMM, PROG_LEN);
        load_program(PROG_LEN, 1'b1);
        finish_test("reset_and_load");
        run_program(PROG_LEN);  // Gives the registers random values
        finish_test("imm_alu");
        build_program(KIND_REG, PROG_LEN);
        load_program(PROG_LEN, 1'b0);
        run_program(PROG_LEN);
        finish_test("reg_alu");
        build_program(KIND_MIX, PROG_LEN);
        load_program(PROG_LEN, 1'b0);
        run_program(PROG_LEN);
        finish_test("load_store");
        build_program(KIND_MIX, RESTART_LEN);
        load_program(RESTART_LEN, 1'b0);
        run_program(RESTART_LEN);
        finish_test("restart");
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== rv_multicycle.f ====
+incdir+common
common/rv_pkg.sv
core/cpu_control.sv
core/pc_counter.sv
core/inst_decoder.sv
core/alu.sv
core/register_file.sv
source/word_mem.sv
source/rv_multicycle_top.sv
test/rv_multicycle_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := rv_multicycle_tb
FILELIST := rv_multicycle.f
BUILD    := obj_dir
LOG      := sim.log

SOURCES  := $(shell grep -v '^+' $(FILELIST)) common/rv_defs.svh
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
